// File: kcpu_defines.svh
`ifndef KCPU_DEFINES_SVH
`define KCPU_DEFINES_SVH

// data and address bus widths
`define KCPU_DW    8
`define KCPU_AW    16

// microcode address is {category, step}
`define KCPU_CATW  4
`define KCPU_STEPW 3
`define KCPU_UAW   (`KCPU_CATW + `KCPU_STEPW)

// one bit per microcode control field
`define KCPU_UDW   18

`endif

// File: kcpu_pkg.sv
`include "kcpu_defines.svh"

package kcpu_pkg;

    typedef logic [`KCPU_DW-1:0]  data_t;
    typedef logic [`KCPU_AW-1:0]  addr_t;
    typedef logic [`KCPU_UAW-1:0] uaddr_t;
    typedef logic [`KCPU_UDW-1:0] uword_t;

    // microcode routines, upper field of the microcode address
    typedef enum logic [`KCPU_CATW-1:0] {
        RESET_R,
        SINGLE_ALU,
        SINGLE_ALU_IDX,
        LDX16,
        STORE8,
        SBRANCH,
        NOPE,
        PARSE_IDX,
        IDX_R,
        IDX_OFFSET8,
        IDX_RINC,
        IDX_EXT,
        BUSERROR
    } opcat_e;

    typedef enum logic [1:0] {LD, ADD, SUB, AND} alu_fn_e;

    typedef enum logic [1:0] {IDLE, REQ, WAITLOW} bus_st_e;

    // opcodes, 6809 encodings
    localparam data_t LDA_IMM  = 8'h86;
    localparam data_t LDA_IDX  = 8'hA6;
    localparam data_t LDB_IMM  = 8'hC6;
    localparam data_t LDB_IDX  = 8'hE6;
    localparam data_t ADDA_IMM = 8'h8B;
    localparam data_t ADDA_IDX = 8'hAB;
    localparam data_t SUBA_IMM = 8'h80;
    localparam data_t SUBA_IDX = 8'hA0;
    localparam data_t ANDA_IMM = 8'h84;
    localparam data_t ANDA_IDX = 8'hA4;
    localparam data_t LDX_IMM  = 8'h8E;
    localparam data_t STA      = 8'hA7;
    localparam data_t STB      = 8'hE7;
    localparam data_t BRA      = 8'h20;
    localparam data_t BNE      = 8'h26;
    localparam data_t NOP      = 8'h12;

    // indexed postbytes
    localparam data_t PB_RINC  = 8'h00; // ,X+
    localparam data_t PB_OFF8  = 8'h04; // n,X
    localparam data_t PB_R     = 8'h06; // ,X
    localparam data_t PB_EXT   = 8'h07; // 16-bit address follows

endpackage

// File: kcpu_alu.sv
`timescale 1ns/100ps
`include "kcpu_defines.svh"

module kcpu_alu (
    input  kcpu_pkg::data_t   a,
    input  kcpu_pkg::data_t   b,
    input  kcpu_pkg::alu_fn_e fn,
    output kcpu_pkg::data_t   y,
    output logic              n,
    output logic              z,
    output logic              v,
    output logic              c
);
    import kcpu_pkg::*;

    logic [`KCPU_DW:0] sum; // extra bit for carry or borrow

    always_comb begin
        sum = '0;
        y   = b;
        v   = 1'b0;
        c   = 1'b0;
        case (fn)
            ADD: begin
                sum = {1'b0, a} + {1'b0, b};
                y   = sum[`KCPU_DW-1:0];
                c   = sum[`KCPU_DW];
                // same sign in, other sign out
                v   = (a[`KCPU_DW-1] == b[`KCPU_DW-1]) && (y[`KCPU_DW-1] != a[`KCPU_DW-1]);
            end
            SUB: begin
                sum = {1'b0, a} - {1'b0, b};
                y   = sum[`KCPU_DW-1:0];
                c   = sum[`KCPU_DW];  // borrow
                v   = (a[`KCPU_DW-1] != b[`KCPU_DW-1]) && (y[`KCPU_DW-1] != a[`KCPU_DW-1]);
            end
            AND: begin
                y = a & b;
            end
            default: begin
                y = b;  // load passes the operand
            end
        endcase
    end

    assign n = y[`KCPU_DW-1];
    assign z = (y == '0);

endmodule

// File: kcpu_regs.sv
`timescale 1ns/100ps
`include "kcpu_defines.svh"

module kcpu_regs (
    input  logic            clk,
    input  logic            rst,
    input  kcpu_pkg::data_t rdata,
    input  logic            fetch_op,
    input  logic            fetch_post,
    input  logic            fetch_opd,
    input  logic            ld_a,
    input  logic            ld_b,
    input  logic            ld_xl,
    input  logic            ld_xh,
    input  logic            pc_inc,
    input  logic            pc_branch,
    input  kcpu_pkg::data_t alu_y,
    input  logic            n,
    input  logic            z,
    input  logic            v,
    input  logic            c,
    input  logic            idx_inc,
    input  kcpu_pkg::addr_t x_next,
    output kcpu_pkg::data_t a,
    output kcpu_pkg::data_t b,
    output kcpu_pkg::addr_t x,
    output kcpu_pkg::addr_t pc,
    output kcpu_pkg::data_t op,
    output kcpu_pkg::data_t postbyte,
    output kcpu_pkg::data_t opd,
    output logic            branch
);
    import kcpu_pkg::*;

    logic [3:0] cc;  // N Z V C

    always_ff @(posedge clk) begin
        if (rst) begin
            a  <= '0;
            b  <= '0;
            x  <= '0;
            pc <= '0;
            cc <= '0;
        end else begin
            if (ld_a) begin
                a  <= alu_y;
                cc <= {n, z, v, c};
            end
            if (ld_b) begin
                b  <= alu_y;
                cc <= {n, z, v, c};
            end
            if (ld_xh) x[`KCPU_AW-1:`KCPU_DW] <= rdata;  // high byte first
            if (ld_xl) x[`KCPU_DW-1:0] <= rdata;
            if (idx_inc) x <= x_next;
            if (pc_inc) begin
                pc <= pc + 1'b1;
            end else if (pc_branch) begin
                pc <= pc + {{(`KCPU_AW-`KCPU_DW){opd[`KCPU_DW-1]}}, opd};
            end
        end
    end

    // bytes from the bus
    always_ff @(posedge clk) begin
        if (fetch_op)   op       <= rdata;
        if (fetch_post) postbyte <= rdata;
        if (fetch_opd)  opd      <= rdata;
    end

    assign branch = (op == BRA) || ((op == BNE) && !cc[2]);

endmodule

// File: kcpu_addr.sv
`timescale 1ns/100ps
`include "kcpu_defines.svh"

module kcpu_addr (
    input  kcpu_pkg::addr_t  x,
    input  kcpu_pkg::addr_t  pc,
    input  kcpu_pkg::data_t  opd,
    input  kcpu_pkg::data_t  opd_hi,
    input  kcpu_pkg::opcat_e idx_mode,
    input  logic             use_idx,
    output kcpu_pkg::addr_t  addr,
    output kcpu_pkg::addr_t  x_next
);
    import kcpu_pkg::*;

    addr_t ea;

    always_comb begin
        ea     = x;
        x_next = x;
        case (idx_mode)
            IDX_OFFSET8: begin
                ea = x + {{(`KCPU_AW-`KCPU_DW){opd[`KCPU_DW-1]}}, opd};
            end
            IDX_RINC: begin
                x_next = x + 1'b1;  // ea stays at old X
            end
            IDX_EXT: begin
                ea = {opd_hi, opd};
            end
            default: begin
                ea = x;
            end
        endcase
    end

    // opcode and immediate fetches run off the PC
    assign addr = use_idx ? ea : pc;

endmodule

// File: kcpu_bus.sv
`timescale 1ns/100ps

module kcpu_bus (
    input  logic            clk,
    input  logic            rst,
    input  logic            bus_go,
    input  logic            bus_we,
    input  kcpu_pkg::addr_t addr,
    input  kcpu_pkg::data_t wdata,
    input  logic            mem_ack,
    input  kcpu_pkg::data_t mem_rdata,
    output logic            mem_req,
    output logic            mem_we,
    output kcpu_pkg::addr_t mem_addr,
    output kcpu_pkg::data_t mem_wdata,
    output kcpu_pkg::data_t rdata,
    output logic            mem_busy,
    output logic            bus_done
);
    import kcpu_pkg::*;

    bus_st_e st;

    always_ff @(posedge clk) begin
        if (rst) begin
            st       <= IDLE;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            bus_done <= 1'b0;
        end else begin
            bus_done <= 1'b0;
            case (st)
                IDLE: if (bus_go) begin
                    st      <= REQ;
                    mem_req <= 1'b1;
                    mem_we  <= bus_we;
                end
                REQ: if (mem_ack) begin
                    st      <= WAITLOW;
                    mem_req <= 1'b0;
                end
                WAITLOW: if (!mem_ack) begin  // handshake closed
                    st       <= IDLE;
                    mem_we   <= 1'b0;
                    bus_done <= 1'b1;
                end
                default: st <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == IDLE && bus_go) begin
            mem_addr  <= addr;
            mem_wdata <= wdata;
        end
        if (st == REQ && mem_ack) rdata <= mem_rdata;
    end

    assign mem_busy = (st != IDLE);

endmodule

// File: kcpu_ucode.sv
`timescale 1ns/100ps
`include "kcpu_defines.svh"

module kcpu_ucode (
    input  logic              clk,
    input  logic              rst,
    input  kcpu_pkg::data_t   op,
    input  kcpu_pkg::data_t   postbyte,
    input  logic              branch,
    input  logic              mem_busy,
    input  logic              bus_done,
    output logic              bus_go,
    output logic              bus_we,
    output logic              fetch_op,
    output logic              fetch_post,
    output logic              fetch_opd,
    output logic              ld_a,
    output logic              ld_b,
    output logic              ld_xl,
    output logic              ld_xh,
    output logic              st_a,
    output logic              st_b,
    output kcpu_pkg::alu_fn_e alu_fn,
    output logic              pc_inc,
    output logic              pc_branch,
    output logic              use_idx,
    output kcpu_pkg::opcat_e  idx_mode,
    output logic              idx_inc,
    output logic              halt
);
    import kcpu_pkg::*;

    localparam logic [`KCPU_STEPW-1:0] STEP0 = '0;

    localparam uword_t M_GO    = uword_t'(1) << 0;  // start a bus access
    localparam uword_t M_WE    = uword_t'(1) << 1;
    localparam uword_t M_FOP   = uword_t'(1) << 2;
    localparam uword_t M_FPOST = uword_t'(1) << 3;
    localparam uword_t M_FOPD  = uword_t'(1) << 4;
    localparam uword_t M_LDACC = uword_t'(1) << 5;  // A or B, by opcode
    localparam uword_t M_LDXL  = uword_t'(1) << 6;
    localparam uword_t M_LDXH  = uword_t'(1) << 7;
    localparam uword_t M_STACC = uword_t'(1) << 8;
    localparam uword_t M_PCINC = uword_t'(1) << 9;
    localparam uword_t M_PCBR  = uword_t'(1) << 10;
    localparam uword_t M_USEIX = uword_t'(1) << 11;
    localparam uword_t M_IXINC = uword_t'(1) << 12;
    localparam uword_t M_NI    = uword_t'(1) << 13; // dispatch on the fetched opcode
    localparam uword_t M_JMP   = uword_t'(1) << 14; // dispatch on the postbyte
    localparam uword_t M_RET   = uword_t'(1) << 15; // back from an index routine
    localparam uword_t M_SKIP  = uword_t'(1) << 16; // skip next step if no branch
    localparam uword_t M_HLT   = uword_t'(1) << 17;

    uaddr_t upc;
    uword_t uw;
    opcat_e opcat;
    opcat_e nx_cat;
    opcat_e ret_cat;
    opcat_e idx_cat;
    logic   strobe_ok;
    logic   step_done;
    logic   sel_b;

    // opcode to routine
    always_comb begin
        nx_cat = ret_cat;
        case (op)
            LDA_IMM, LDB_IMM, ADDA_IMM, SUBA_IMM, ANDA_IMM: opcat = SINGLE_ALU;
            LDA_IDX, LDB_IDX, ADDA_IDX, SUBA_IDX, ANDA_IDX: begin
                opcat  = PARSE_IDX;
                nx_cat = SINGLE_ALU_IDX;
            end
            STA, STB: begin
                opcat  = PARSE_IDX;
                nx_cat = STORE8;
            end
            LDX_IMM:  opcat = LDX16;
            BRA, BNE: opcat = SBRANCH;
            NOP:      opcat = NOPE;
            default:  opcat = BUSERROR;
        endcase
    end

    always_comb begin
        case (postbyte)
            PB_R:    idx_cat = IDX_R;
            PB_OFF8: idx_cat = IDX_OFFSET8;
            PB_RINC: idx_cat = IDX_RINC;
            PB_EXT:  idx_cat = IDX_EXT;
            default: idx_cat = BUSERROR;
        endcase
    end

    // low nibble selects the ALU function
    always_comb begin
        case (op[3:0])
            4'hB:    alu_fn = ADD;
            4'h0:    alu_fn = SUB;
            4'h4:    alu_fn = AND;
            default: alu_fn = LD;
        endcase
    end

    // microcode ROM
    always_comb begin
        case (upc)
            {RESET_R, 3'd0}:        uw = M_GO | M_FOP | M_PCINC;
            {RESET_R, 3'd1}:        uw = M_NI;
            {SINGLE_ALU, 3'd0}:     uw = M_GO | M_FOPD | M_PCINC;
            {SINGLE_ALU, 3'd1}:     uw = M_LDACC;
            {SINGLE_ALU, 3'd2}:     uw = M_GO | M_FOP | M_PCINC;
            {SINGLE_ALU, 3'd3}:     uw = M_NI;
            {SINGLE_ALU_IDX, 3'd0}: uw = M_GO | M_FOPD | M_USEIX | M_IXINC;
            {SINGLE_ALU_IDX, 3'd1}: uw = M_LDACC;
            {SINGLE_ALU_IDX, 3'd2}: uw = M_GO | M_FOP | M_PCINC;
            {SINGLE_ALU_IDX, 3'd3}: uw = M_NI;
            {LDX16, 3'd0}:          uw = M_GO | M_LDXH | M_PCINC;
            {LDX16, 3'd1}:          uw = M_GO | M_LDXL | M_PCINC;
            {LDX16, 3'd2}:          uw = M_GO | M_FOP | M_PCINC;
            {LDX16, 3'd3}:          uw = M_NI;
            {STORE8, 3'd0}:         uw = M_GO | M_WE | M_STACC | M_USEIX | M_IXINC;
            {STORE8, 3'd1}:         uw = M_GO | M_FOP | M_PCINC;
            {STORE8, 3'd2}:         uw = M_NI;
            {SBRANCH, 3'd0}:        uw = M_GO | M_FOPD | M_PCINC;
            {SBRANCH, 3'd1}:        uw = M_SKIP;
            {SBRANCH, 3'd2}:        uw = M_PCBR;
            {SBRANCH, 3'd3}:        uw = M_GO | M_FOP | M_PCINC;
            {SBRANCH, 3'd4}:        uw = M_NI;
            {NOPE, 3'd0}:           uw = M_GO | M_FOP | M_PCINC;
            {NOPE, 3'd1}:           uw = M_NI;
            {PARSE_IDX, 3'd0}:      uw = M_GO | M_FPOST | M_PCINC;
            {PARSE_IDX, 3'd1}:      uw = M_JMP;
            {IDX_R, 3'd0}:          uw = M_RET;
            {IDX_OFFSET8, 3'd0}:    uw = M_GO | M_FOPD | M_PCINC;
            {IDX_OFFSET8, 3'd1}:    uw = M_RET;
            {IDX_RINC, 3'd0}:       uw = M_RET; // increment happens on the access
            // high address byte lands in the postbyte latch
            {IDX_EXT, 3'd0}:        uw = M_GO | M_FPOST | M_PCINC;
            {IDX_EXT, 3'd1}:        uw = M_GO | M_FOPD | M_PCINC;
            {IDX_EXT, 3'd2}:        uw = M_RET;
            default:                uw = M_HLT; // BUSERROR and unused rows
        endcase
    end

    // strobes of a bus step fire with bus_done
    assign strobe_ok = !(|(uw & M_GO)) || bus_done;
    assign step_done = !mem_busy && strobe_ok;
    assign sel_b     = op[6];  // B-register opcodes

    assign bus_go     = |(uw & M_GO) && !mem_busy && !bus_done && !halt;
    assign bus_we     = |(uw & M_WE);
    assign fetch_op   = |(uw & M_FOP) && strobe_ok;
    assign fetch_post = |(uw & M_FPOST) && strobe_ok;
    assign fetch_opd  = |(uw & M_FOPD) && strobe_ok;
    assign ld_a       = |(uw & M_LDACC) && !sel_b && strobe_ok;
    assign ld_b       = |(uw & M_LDACC) && sel_b && strobe_ok;
    assign ld_xl      = |(uw & M_LDXL) && strobe_ok;
    assign ld_xh      = |(uw & M_LDXH) && strobe_ok;
    assign st_a       = |(uw & M_STACC) && !sel_b; // write data captured at bus_go
    assign st_b       = |(uw & M_STACC) && sel_b;
    assign pc_inc     = |(uw & M_PCINC) && strobe_ok;
    assign pc_branch  = |(uw & M_PCBR) && strobe_ok;
    assign use_idx    = |(uw & M_USEIX);
    assign idx_inc    = |(uw & M_IXINC) && strobe_ok;

    // sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            upc      <= {RESET_R, STEP0};
            ret_cat  <= NOPE;
            idx_mode <= IDX_R;
            halt     <= 1'b0;
        end else if (!halt) begin
            if (|(uw & M_HLT)) begin
                halt <= 1'b1;  // frozen until reset
            end else if (step_done) begin
                if (|(uw & M_NI)) begin
                    upc <= {opcat, STEP0};
                    if (opcat == PARSE_IDX) ret_cat <= nx_cat;
                end else if (|(uw & M_JMP)) begin
                    upc      <= {idx_cat, STEP0};
                    idx_mode <= idx_cat;
                end else if (|(uw & M_RET)) begin
                    upc <= {ret_cat, STEP0};
                end else if (|(uw & M_SKIP) && !branch) begin
                    upc <= upc + 2'd2;
                end else begin
                    upc <= upc + 1'b1;
                end
            end
        end
    end

endmodule

// File: kcpu_top.sv
`timescale 1ns/100ps

module kcpu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_ack,
    input  kcpu_pkg::data_t mem_rdata,
    output logic            mem_req,
    output logic            mem_we,
    output kcpu_pkg::addr_t mem_addr,
    output kcpu_pkg::data_t mem_wdata,
    output logic            halt
);
    import kcpu_pkg::*;

    data_t   rdata, a, b, op, postbyte, opd, alu_y, wdata;
    addr_t   x, pc, addr, x_next;
    alu_fn_e alu_fn;
    opcat_e  idx_mode;
    logic    bus_go, bus_we, mem_busy, bus_done, branch;
    logic    fetch_op, fetch_post, fetch_opd;
    logic    ld_a, ld_b, ld_xl, ld_xh, st_a, st_b;
    logic    pc_inc, pc_branch, use_idx, idx_inc;
    logic    n, z, v, c;

    assign wdata = ({$bits(data_t){st_a}} & a) | ({$bits(data_t){st_b}} & b);

    kcpu_ucode ucode_i (
        .clk, .rst, .op, .postbyte, .branch, .mem_busy, .bus_done,
        .bus_go, .bus_we, .fetch_op, .fetch_post, .fetch_opd,
        .ld_a, .ld_b, .ld_xl, .ld_xh, .st_a, .st_b, .alu_fn,
        .pc_inc, .pc_branch, .use_idx, .idx_mode, .idx_inc, .halt
    );

    // accumulator A against the latched operand
    kcpu_alu alu_i (.a(a), .b(opd), .fn(alu_fn), .y(alu_y), .n, .z, .v, .c);

    kcpu_regs regs_i (
        .clk, .rst, .rdata, .fetch_op, .fetch_post, .fetch_opd,
        .ld_a, .ld_b, .ld_xl, .ld_xh, .pc_inc, .pc_branch,
        .alu_y, .n, .z, .v, .c, .idx_inc, .x_next,
        .a, .b, .x, .pc, .op, .postbyte, .opd, .branch
    );

    // postbyte latch holds the high byte of an extended address
    kcpu_addr addr_i (
        .x, .pc, .opd, .opd_hi(postbyte), .idx_mode, .use_idx, .addr, .x_next
    );

    kcpu_bus bus_i (
        .clk, .rst, .bus_go, .bus_we, .addr, .wdata, .mem_ack, .mem_rdata,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .rdata, .mem_busy, .bus_done
    );

endmodule

// File: kcpu_tb_clk.sv
`timescale 1ns/100ps

module kcpu_tb_clk (
    input  logic restart,
    output logic clk,
    output logic rst
);
    logic [1:0] cnt = 2'd2;  // cycles of reset still to go

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (restart) cnt <= 2'd2;
        else if (cnt != 0) cnt <= cnt - 1'b1;
    end

    always @(negedge clk) rst <= (cnt != 0);  // moves on the falling edge

endmodule

// File: kcpu_tb_mon.sv
`timescale 1ns/100ps

module kcpu_tb_mon (
    input  logic            clk,
    input  logic            mem_req,
    input  logic            mem_we,
    input  kcpu_pkg::addr_t mem_addr,
    input  kcpu_pkg::data_t mem_wdata,
    input  kcpu_pkg::addr_t exp_addr [4],
    input  kcpu_pkg::data_t exp_data [4],
    input  int              exp_cnt
);
    import kcpu_pkg::*;

    int   errors = 0;
    int   wcnt   = 0;
    logic req_q  = 1'b0;

    task automatic start_test();
        wcnt = 0;
    endtask

    // called once the core has halted and gone quiet
    task automatic check_end(input logic halted, input logic exp_halt);
        if (wcnt < exp_cnt) begin
            $display("only %0d of %0d expected writes were seen", wcnt, exp_cnt);
            errors++;
        end
        if (halted !== exp_halt) begin
            $display("halt is %b at the end of the test, expected %b", halted, exp_halt);
            errors++;
        end
    endtask

    // outputs settle after the rising edge, look at them on the falling one
    always @(negedge clk) begin
        if (mem_req && !req_q && mem_we) begin
            if (wcnt >= exp_cnt) begin
                $display("unexpected write to %h at %0t", mem_addr, $time);
                errors++;
            end else begin
                if (mem_addr !== exp_addr[wcnt]) begin
                    $display("Mismatch at %0t: mem_addr got %h expected %h",
                             $time, mem_addr, exp_addr[wcnt]);
                    errors++;
                end
                if (mem_wdata !== exp_data[wcnt]) begin
                    $display("Mismatch at %0t: mem_wdata got %h expected %h",
                             $time, mem_wdata, exp_data[wcnt]);
                    errors++;
                end
            end
            wcnt++;
        end
        req_q = mem_req;
    end

endmodule

// File: kcpu_chk.sv
`timescale 1ns/100ps

module kcpu_chk (
    input logic            clk,
    input logic            rst,
    input logic            mem_req,
    input logic            mem_ack,
    input logic            halt,
    input kcpu_pkg::addr_t mem_addr,
    input kcpu_pkg::data_t mem_wdata
);
    int fails = 0;

    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
        else begin
            fails++;
            $error("req dropped before ack");
        end

    // ack of the previous access must be gone before req comes back
    no_rise_on_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) |-> !$past(mem_ack))
        else begin
            fails++;
            $error("req rose while ack still high");
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
        halt |-> !mem_req)
        else begin
            fails++;
            $error("bus request after halt");
        end

    stable_req: assert property (@(posedge clk) disable iff (rst)
        mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_wdata)))
        else begin
            fails++;
            $error("address or write data moved during req");
        end

endmodule

bind kcpu_top kcpu_chk chk_i (
    .clk, .rst, .mem_req, .mem_ack, .halt, .mem_addr, .mem_wdata
);

// File: kcpu_tb.sv
`timescale 1ns/100ps
`include "kcpu_defines.svh"

module kcpu_tb;
    import kcpu_pkg::*;

    localparam int    NT  = 7;
    localparam data_t ILL = 8'h01;  // not an opcode, not a postbyte

    logic  clk, rst, restart, mem_ack, mem_req, mem_we, halt;
    data_t mem_rdata, mem_wdata;
    addr_t mem_addr;
    data_t mem [0:65535];

    data_t prog [NT][$];
    addr_t ea [NT][4];
    data_t ed [NT][4];
    int    en [NT];
    addr_t cur_a [4];
    data_t cur_d [4];
    int    cur_n;
    int    failed, errs_before;

    kcpu_tb_clk clk_i (.restart, .clk, .rst);

    kcpu_top dut_i (
        .clk, .rst, .mem_ack, .mem_rdata, .mem_req, .mem_we, .mem_addr, .mem_wdata, .halt
    );

    kcpu_tb_mon mon_i (
        .clk, .mem_req, .mem_we, .mem_addr, .mem_wdata,
        .exp_addr(cur_a), .exp_data(cur_d), .exp_cnt(cur_n)
    );

    task automatic expect_write(input int t, input addr_t a, input data_t d);
        ea[t][en[t]] = a;
        ed[t][en[t]] = d;
        en[t]++;
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < 65536; i++) mem[i] = 8'(i ^ (i >> 8)) ^ 8'hc3;
        for (int j = 0; j < prog[t].size(); j++) mem[j] = prog[t][j];
        for (int k = 0; k < 4; k++) begin
            cur_a[k] = ea[t][k];
            cur_d[k] = ed[t][k];
        end
        cur_n = en[t];
    endtask

    // memory: ack after 0..3 falling edges, held until req drops
    initial begin
        void'($urandom(32'h6d4c_a43d));
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                repeat ($urandom % 4) @(negedge clk);
                if (mem_we) mem[mem_addr] = mem_wdata;
                mem_rdata = mem[mem_addr];
                mem_ack   = 1'b1;
                do @(negedge clk); while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    initial begin
        #(NT * 400 * 4);
        $display("timeout: the core never reached halt");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        restart = 1'b0;
        failed  = 0;
        foreach (en[t]) en[t] = 0;
        // ALU chain, result stored to an extended address
        prog[0] = '{LDA_IMM, 8'h35, ADDA_IMM, 8'h4c, SUBA_IMM, 8'h12, ANDA_IMM, 8'h5a,
                    STA, PB_EXT, 8'h12, 8'h34, ILL};
        expect_write(0, 16'h1234, data_t'((8'h35 + 8'h4c - 8'h12) & 8'h5a));
        prog[1] = '{LDX_IMM, 8'h20, 8'h00, LDA_IMM, 8'ha5, STA, PB_OFF8, 8'hf0,
                    STA, PB_OFF8, 8'h10, ILL};
        expect_write(1, 16'h2000 - 16'h10, 8'ha5);
        expect_write(1, 16'h2000 + 16'h10, 8'ha5);
        prog[2] = '{LDX_IMM, 8'h30, 8'h00, LDB_IMM, 8'h77, STB, PB_RINC,
                    LDB_IMM, 8'h88, STB, PB_RINC, ILL};
        expect_write(2, 16'h3000, 8'h77);
        expect_write(2, 16'h3001, 8'h88);
        // BNE falls through on zero, then BNE and BRA jump over stores
        prog[3] = '{LDX_IMM, 8'h40, 8'h00, LDA_IMM, 8'h05, SUBA_IMM, 8'h05, BNE, 8'h02,
                    STA, PB_R, LDA_IMM, 8'h09, BNE, 8'h02, STA, PB_R, BRA, 8'h02,
                    STA, PB_R, LDB_IMM, 8'h3c, STB, PB_OFF8, 8'h01, NOP, ILL};
        expect_write(3, 16'h4000, 8'h00);
        expect_write(3, 16'h4001, 8'h3c);
        prog[4] = '{LDX_IMM, 8'h50, 8'h00, LDA_IMM, 8'h11, ILL, STA, PB_R};
        prog[5] = '{LDX_IMM, 8'h50, 8'h00, LDA_IMM, 8'h22, STA, ILL, STA, PB_R, ILL};
        // indexed loads, data at 0x1c..0x20
        prog[6] = '{LDX_IMM, 8'h00, 8'h1c, LDA_IDX, PB_RINC, ADDA_IDX, PB_RINC,
                    SUBA_IDX, PB_RINC, ANDA_IDX, PB_R, LDB_IDX, PB_OFF8, 8'h01,
                    STA, PB_EXT, 8'h00, 8'h60, STB, PB_EXT, 8'h00, 8'h61, ILL,
                    ILL, ILL, ILL, ILL, ILL, 8'h5e, 8'h33, 8'h27, 8'h3c, 8'h91};
        expect_write(6, 16'h0060, data_t'((8'h5e + 8'h33 - 8'h27) & 8'h3c));
        expect_write(6, 16'h0061, 8'h91);
        for (int t = 0; t < NT; t++) begin
            errs_before = mon_i.errors + dut_i.chk_i.fails;
            @(negedge clk);
            load_program(t);
            mon_i.start_test();
            restart = 1'b1;
            @(negedge clk);
            restart = 1'b0;
            wait (rst);
            wait (!rst);
            wait (halt);
            repeat (8) @(negedge clk);  // no write may follow the halt
            mon_i.check_end(halt, 1'b1);
            if (mon_i.errors + dut_i.chk_i.fails != errs_before) begin
                failed++;
                $display("test %0d: failed", t);
            end else begin
                $display("test %0d: ok, %0d writes", t, en[t]);
            end
        end
        $display("%0d tests, %0d failed, %0d errors", NT, failed,
                 mon_i.errors + dut_i.chk_i.fails);
        if (failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: kcpu.f
+incdir+.
kcpu_pkg.sv
kcpu_alu.sv
kcpu_regs.sv
kcpu_addr.sv
kcpu_bus.sv
kcpu_ucode.sv
kcpu_top.sv
kcpu_tb_clk.sv
kcpu_tb_mon.sv
kcpu_chk.sv
kcpu_tb.sv

// File: Bender.yml
package:
  name: kcpu

export_include_dirs:
  - .

sources:
  - kcpu_pkg.sv
  - kcpu_alu.sv
  - kcpu_regs.sv
  - kcpu_addr.sv
  - kcpu_bus.sv
  - kcpu_ucode.sv
  - kcpu_top.sv
  - target: test
    files:
      - kcpu_tb_clk.sv
      - kcpu_tb_mon.sv
      - kcpu_chk.sv
      - kcpu_tb.sv
